// File: dino_game.f
+incdir+bench
design/dino_game_pkg.sv
design/dino_sprite_pkg.sv
design/jump_controller.sv
design/dino_renderer.sv
design/dino_game_top.sv
bench/dino_game_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module dino_game_tb -f dino_game.f -o dino_sim \
    && ./obj_dir/dino_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0

// File: bench/dino_model.svh
`ifndef DINO_MODEL_SVH
`define DINO_MODEL_SVH

    // reference state stepped on every rising edge
    int   m_time;       // frames into the jump
    logic m_jumping;
    logic m_success;
    int   m_frames;     // frame counter modulo 16
    logic m_pixel;

    // parabola over the jump that is zero at both ends
    function automatic int model_height(input int t);
        return (t * int'(jump_frames) - t * t) / 2;
    endfunction

    function automatic void model_reset();
        m_time    = 0;
        m_jumping = 1'b0;
        m_success = 1'b0;
        m_frames  = 0;
        m_pixel   = 1'b0;
    endfunction

    function automatic logic model_pixel(input int h, input int v, input game_state_e st);
        int         hgt;
        int         feet_end;
        int         feet_start;
        int         body_start;
        logic       running;
        logic [6:0] col;
        logic [6:0] body_row;
        logic [3:0] feet_row;
        hgt        = model_height(m_time);
        feet_end   = int'(ground_y) - hgt;
        feet_start = feet_end - int'(feet_h);
        body_start = feet_start - int'(body_h);
        running    = (st == st_play || st == st_bot) && (hgt == 0);
        col        = 7'(h - int'(dino_x));
        body_row   = 7'(v - body_start);
        feet_row   = 4'(v - feet_start);
        if (h < int'(dino_x) || h >= int'(dino_x) + int'(dino_w)) begin
            return 1'b0;
        end
        if (v >= feet_start && v < feet_end) begin
            if (!running) begin
                return feet_stop_bmp[feet_row][col];
            end
            return (m_frames >= 8) ? feet_run_a_bmp[feet_row][col] : feet_run_b_bmp[feet_row][col];
        end
        if (v >= body_start && v < feet_start) begin
            return body_bmp[body_row][col];
        end
        return 1'b0;
    endfunction

    // start, advance or land in play and bot modes
    function automatic void model_jump_rule(input logic trig, input logic ack);
        if (!m_jumping) begin
            m_jumping = trig;
            m_success = trig && ack;
        end else if (m_time == int'(jump_frames)) begin
            m_time    = 0;
            m_jumping = 1'b0;
        end else begin
            m_time = m_time + 1;
        end
    endfunction

    function automatic void model_advance(input logic tick, input game_state_e st,
                                          input logic btn, input logic bot_req,
                                          input int h, input int v);
        m_pixel   = model_pixel(h, v, st);  // uses the height before this edge
        m_success = 1'b0;
        if (tick) begin
            m_frames = (m_frames + 1) % 16;
            case (st)
                st_initial: begin
                    m_time    = 0;
                    m_jumping = btn;
                end
                st_play: model_jump_rule(btn, 1'b0);
                st_bot:  model_jump_rule(bot_req, 1'b1);
                default: ;
            endcase
        end
    endfunction

`endif

// File: bench/dino_game_tb.sv
`timescale 1ns/10ps

module dino_game_tb;
    import dino_game_pkg::*;
    import dino_sprite_pkg::*;

    localparam int random_cycles = 8000;
    localparam int tick_limit    = 120;    // frame ticks allowed per wait

    logic        clk = 1'b0;
    logic        rst;
    logic        new_frame;
    game_state_e state;
    logic        jump_op;
    logic        q_jump;
    coord_t      h_cnt;
    coord_t      v_cnt;
    logic        black_dino;
    logic        success_jump;
    logic        jumping;

    int mismatch_count;
    int timeout_count;

    `include "dino_model.svh"

    dino_game_top uut (
        .clk          (clk),
        .rst          (rst),
        .new_frame    (new_frame),
        .state        (state),
        .jump_op      (jump_op),
        .q_jump       (q_jump),
        .h_cnt        (h_cnt),
        .v_cnt        (v_cnt),
        .black_dino   (black_dino),
        .success_jump (success_jump),
        .jumping      (jumping)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            model_reset();
        end else begin
            model_advance(new_frame, state, jump_op, q_jump, int'(h_cnt), int'(v_cnt));
        end
    end

    task automatic compare_bit(input logic got, input logic want, input string what);
        assert (got === want) else begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic compare_count(input int got, input int want, input string what);
        assert (got == want) else begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // outputs settle after the rising edge, so look on the falling one
    task automatic next_cycle();
        @(negedge clk);
        compare_bit(jumping, m_jumping, "jumping");
        compare_bit(success_jump, m_success, "success_jump");
        compare_bit(black_dino, m_pixel, "black_dino");
    endtask

    task automatic random_scan();
        if ($urandom_range(1, 0) == 1) begin
            h_cnt = coord_t'($urandom_range(int'(dino_x + dino_w) + 8, int'(dino_x) - 8));
            v_cnt = coord_t'($urandom_range(int'(ground_y) + 4, int'(ground_y) - 200));
        end else begin
            h_cnt = coord_t'($urandom_range(1023, 0));
            v_cnt = coord_t'($urandom_range(1023, 0));
        end
    endtask

    // one tick cycle, then one quiet cycle
    task automatic frame_tick();
        new_frame = 1'b1;
        random_scan();
        next_cycle();
        new_frame = 1'b0;
        random_scan();
        next_cycle();
    endtask

    task automatic wait_jumping(input logic level, output int ticks);
        ticks = 0;
        while (jumping !== level && ticks < tick_limit) begin
            frame_tick();
            ticks++;
        end
        assert (jumping === level) else begin
            timeout_count++;
            $display("timeout at %0t: jumping never went to %b", $time, level);
        end
    endtask

    task automatic wait_success(output int ticks);
        logic seen;
        seen  = 1'b0;
        ticks = 0;
        while (!seen && ticks < tick_limit) begin
            new_frame = 1'b1;
            random_scan();
            next_cycle();
            new_frame = 1'b0;
            ticks++;
            seen = (success_jump === 1'b1);
        end
        assert (seen) else begin
            timeout_count++;
            $display("timeout at %0t: success_jump never pulsed", $time);
        end
    endtask

    function automatic game_state_e pick_state();
        int r;
        r = $urandom_range(99, 0);
        if (r < 40) return st_play;
        if (r < 75) return st_bot;
        if (r < 85) return st_initial;
        return st_dead;
    endfunction

    initial begin
        int run_left;
        int ticks;
        void'($urandom(41));
        rst            = 1'b1;
        new_frame      = 1'b0;
        state          = st_initial;
        jump_op        = 1'b0;
        q_jump         = 1'b0;
        h_cnt          = '0;
        v_cnt          = '0;
        mismatch_count = 0;
        timeout_count  = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        repeat (4) begin
            next_cycle();
            compare_bit(jumping, 1'b0, "jumping after reset");
            compare_bit(success_jump, 1'b0, "success_jump after reset");
            compare_bit(black_dino, 1'b0, "black_dino after reset");
        end

        // play mode takes the button and ignores the bot request
        state   = st_play;
        jump_op = 1'b0;
        q_jump  = 1'b1;
        frame_tick();
        frame_tick();
        compare_bit(jumping, 1'b0, "jumping on bot request in play mode");
        jump_op = 1'b1;
        wait_jumping(1'b1, ticks);
        compare_count(ticks, 1, "ticks to start a play jump");
        wait_jumping(1'b0, ticks);
        compare_count(ticks, int'(jump_frames) + 1, "play jump length in ticks");
        jump_op = 1'b0;
        q_jump  = 1'b0;

        // bot mode takes only q_jump and acknowledges once
        state   = st_bot;
        jump_op = 1'b1;
        frame_tick();
        frame_tick();
        compare_bit(jumping, 1'b0, "jumping on button in bot mode");
        q_jump = 1'b1;
        wait_success(ticks);
        compare_count(ticks, 1, "ticks to bot acknowledge");
        compare_bit(jumping, 1'b1, "jumping with acknowledge");
        next_cycle();
        compare_bit(success_jump, 1'b0, "success_jump one cycle later");
        wait_jumping(1'b0, ticks);
        compare_count(ticks, int'(jump_frames) + 1, "bot jump length in ticks");
        q_jump  = 1'b0;
        jump_op = 1'b0;

        state   = st_initial;
        jump_op = 1'b1;
        frame_tick();
        compare_bit(jumping, 1'b1, "jumping follows button in initial");
        jump_op = 1'b0;
        frame_tick();
        compare_bit(jumping, 1'b0, "jumping follows button in initial");

        // freeze in mid air just before landing
        state   = st_play;
        jump_op = 1'b1;
        wait_jumping(1'b1, ticks);
        jump_op = 1'b0;
        repeat (int'(jump_frames) - 2) frame_tick();
        state   = st_dead;
        repeat (6) frame_tick();
        compare_bit(jumping, 1'b1, "jumping frozen in dead state");

        run_left = 0;
        for (int i = 0; i < random_cycles; i++) begin
            if (run_left == 0) begin
                state    = pick_state();
                run_left = $urandom_range(400, 40);
            end
            run_left--;
            new_frame = ($urandom_range(4, 0) == 0);
            jump_op   = ($urandom_range(7, 0) == 0);
            q_jump    = ($urandom_range(7, 0) == 0);
            random_scan();
            next_cycle();
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: design/dino_game_top.sv
`timescale 1ns/10ps

module dino_game_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       new_frame,
    input  dino_game_pkg::game_state_e state,
    input  logic                       jump_op,
    input  logic                       q_jump,
    input  dino_game_pkg::coord_t      h_cnt,
    input  dino_game_pkg::coord_t      v_cnt,
    output logic                       black_dino,
    output logic                       success_jump,
    output logic                       jumping
);
    import dino_game_pkg::*;

    height_t height;
    logic    stride;
    logic    feet_running;

    jump_controller u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .new_frame    (new_frame),
        .state        (state),
        .jump_op      (jump_op),
        .q_jump       (q_jump),
        .jumping      (jumping),
        .success_jump (success_jump),
        .height       (height),
        .stride       (stride),
        .feet_running (feet_running)
    );

    dino_renderer u_render (
        .clk          (clk),
        .rst          (rst),
        .h_cnt        (h_cnt),
        .v_cnt        (v_cnt),
        .height       (height),
        .stride       (stride),
        .feet_running (feet_running),
        .black_dino   (black_dino)
    );

endmodule

// File: design/dino_renderer.sv
`timescale 1ns/10ps

module dino_renderer (
    input  logic                   clk,
    input  logic                   rst,
    input  dino_game_pkg::coord_t  h_cnt,
    input  dino_game_pkg::coord_t  v_cnt,
    input  dino_game_pkg::height_t height,
    input  logic                   stride,
    input  logic                   feet_running,
    output logic                   black_dino
);
    import dino_game_pkg::*;
    import dino_sprite_pkg::*;

    logic [11:0] v_pos;
    logic [11:0] feet_bot;      // one past the last feet row
    logic [11:0] feet_top;
    logic [11:0] body_top;
    logic [11:0] body_row;
    logic [11:0] feet_row;
    coord_t      col;
    logic        in_cols;
    logic        in_body;
    logic        in_feet;
    sprite_row_t feet_line;
    logic        pixel;

    assign v_pos    = {2'b00, v_cnt};
    assign feet_bot = height_t'(ground_y) - height;
    assign feet_top = feet_bot - height_t'(feet_h);
    assign body_top = feet_top - height_t'(body_h);

    assign col      = h_cnt - dino_x;
    assign body_row = v_pos - body_top;
    assign feet_row = v_pos - feet_top;

    assign in_cols = (h_cnt >= dino_x) && (h_cnt < dino_x + dino_w);
    assign in_body = (v_pos >= body_top) && (v_pos < feet_top);
    assign in_feet = (v_pos >= feet_top) && (v_pos < feet_bot);

    always_comb begin
        if (!feet_running) begin
            feet_line = feet_stop_bmp[feet_row[3:0]];
        end else if (stride) begin
            feet_line = feet_run_a_bmp[feet_row[3:0]];
        end else begin
            feet_line = feet_run_b_bmp[feet_row[3:0]];
        end

        pixel = 1'b0;
        if (in_cols && in_feet) begin
            pixel = feet_line[col[6:0]];
        end else if (in_cols && in_body) begin
            pixel = body_bmp[body_row[6:0]][col[6:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            black_dino <= 1'b0;
        end else begin
            black_dino <= pixel;
        end
    end

endmodule

// File: design/jump_controller.sv
`timescale 1ns/10ps

module jump_controller (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       new_frame,
    input  dino_game_pkg::game_state_e state,
    input  logic                       jump_op,
    input  logic                       q_jump,
    output logic                       jumping,
    output logic                       success_jump,
    output dino_game_pkg::height_t     height,
    output logic                       stride,
    output logic                       feet_running
);
    import dino_game_pkg::*;

    jump_time_t jump_time;
    logic [3:0] stride_cnt;     // feet swap every 8 frames
    logic       trigger;

    // player button in play mode, bot request in bot mode
    assign trigger = (state == st_bot) ? q_jump : jump_op;

    // parabola peaking halfway through the jump
    assign height = (jump_time * jump_frames - jump_time * jump_time) >> 1;

    assign stride       = stride_cnt[3];
    assign feet_running = (state == st_play || state == st_bot) && (height == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            jump_time    <= '0;
            jumping      <= 1'b0;
            success_jump <= 1'b0;
            stride_cnt   <= '0;
        end else begin
            success_jump <= 1'b0;   // one cycle only
            if (new_frame) begin
                stride_cnt <= stride_cnt + 4'd1;
                case (state)
                    st_initial: begin
                        jump_time <= '0;
                        jumping   <= jump_op;
                    end
                    st_play, st_bot: begin
                        if (trigger && !jumping) begin
                            jumping      <= 1'b1;   // timer stays put on the start frame
                            success_jump <= (state == st_bot);
                        end else if (jumping) begin
                            if (jump_time >= jump_frames) begin
                                jump_time <= '0;
                                jumping   <= 1'b0;
                            end else begin
                                jump_time <= jump_time + 12'd1;
                            end
                        end
                    end
                    default: ;  // dead state holds everything
                endcase
            end
        end
    end

endmodule

// File: design/dino_sprite_pkg.sv
package dino_sprite_pkg;

    typedef logic [0:81] sprite_row_t;  // bit 0 is the leftmost column

    localparam sprite_row_t body_bmp [0:73] = '{
        82'b0000000000000000000000000000000000000000000000001111111111111111111111111111111100,
        82'b0000000000000000000000000000000000000000000000001111111111111111111111111111111100,
        82'b0000000000000000000000000000000000000000000000001111111111111111111111111111111100,
        82'b0000000000000000000000000000000000000000000000001111111111111111111111111111111100,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111000111111111111111111111111111, // eye
        82'b0000000000000000000000000000000000000000000011111111000111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111000111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111111111111111111111111,
        82'b0000000000000000000000000000000000000000000011111111111111111110000000000000000000,
        82'b0000000000000000000000000000000000000000000011111111111111111110000000000000000000,
        82'b0000000000000000000000000000000000000000000011111111111111111110000000000000000000,
        82'b1111000000000000000000000000000000000000111111111111111111111111111111111111111100,
        82'b1111000000000000000000000000000000000000111111111111111111111111111111111111111100,
        82'b1111000000000000000000000000000000001111111111111111111111110000000000000000000000,
        82'b1111000000000000000000000000000000001111111111111111111111110000000000000000000000,
        82'b1111000000000000000000000000000000111111111111111111111111110000000000000000000000,
        82'b1111000000000000000000000000000000111111111111111111111111110000000000000000000000,
        82'b1111110000000000000000000000000011111111111111111111111111110000000000000000000000,
        82'b1111110000000000000000000000000011111111111111111111111111110000000000000000000000,
        82'b1111111100000000000000000000001111111111111111111111111111110000000000000000000000,
        82'b1111111100000000000000000000001111111111111111111111111111110000000000000000000000,
        82'b1111111111000000000000000011111111111111111111111111111111110000000000000000000000,
        82'b1111111111000000000000000011111111111111111111111111111111110000000000000000000000,
        82'b1111111111110000000000001111111111111111111111111111111111111111111100000000000000, // arm
        82'b1111111111110000000000001111111111111111111111111111111111111111111100000000000000,
        82'b1111111111111100000011111111111111111111111111111111111111111111111100000000000000,
        82'b1111111111111100000011111111111111111111111111111111111111111111111100000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000111100000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000111100000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000111100000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000111100000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b1111111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b0011111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b0011111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b0000111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b0000111111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b0000001111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b0000001111111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b0000000011111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b0000000011111111111111111111111111111111111111111111111111110000000000000000000000,
        82'b0000000000111111111111111111111111111111111111111111111111000000000000000000000000,
        82'b0000000000111111111111111111111111111111111111111111111111000000000000000000000000,
        82'b0000000000001111111111111111111111111111111111111111110000000000000000000000000000,
        82'b0000000000001111111111111111111111111111111111111111110000000000000000000000000000,
        82'b0000000000000011111111111111111111111111111111111100000000000000000000000000000000,
        82'b0000000000000011111111111111111111111111111111111100000000000000000000000000000000,
        82'b0000000000000000111111111111111111111111111111110000000000000000000000000000000000,
        82'b0000000000000000111111111111111111111111111111110000000000000000000000000000000000,
        82'b0000000000000000001111111111111111111111111111000000000000000000000000000000000000,
        82'b0000000000000000001111111111111111111111111111000000000000000000000000000000000000,
        82'b0000000000000000000011111111111111111111111100000000000000000000000000000000000000,
        82'b0000000000000000000011111111111111111111111100000000000000000000000000000000000000
    };

    // both legs planted, used in the air and when the game is idle
    localparam sprite_row_t feet_stop_bmp [0:13] = '{
        82'b0000000000000000000011111111111100001111111100000000000000000000000000000000000000,
        82'b0000000000000000000011111111111100001111111100000000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000011111100000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000011110000000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000011110000000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000011110000000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000011110000000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000111111110000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000111111110000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000111111110000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000111111110000000000000000000000000000000000
    };

    localparam sprite_row_t feet_run_a_bmp [0:13] = '{
        82'b0000000000000000000011111111000000001111111100000000000000000000000000000000000000,
        82'b0000000000000000000011111111000000001111111100000000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000000111111111111000000111100000000000000000000000000000000000000,
        82'b0000000000000000000000111111111111000000111100000000000000000000000000000000000000,
        82'b0000000000000000000000000000000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000000000000000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000000000000000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000000000000000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000000000000000000000000111100000000000000000000000000000000000000,
        82'b0000000000000000000000000000000000000000111111110000000000000000000000000000000000,
        82'b0000000000000000000000000000000000000000111111110000000000000000000000000000000000,
        82'b0000000000000000000000000000000000000000111111110000000000000000000000000000000000,
        82'b0000000000000000000000000000000000000000111111110000000000000000000000000000000000
    };

    localparam sprite_row_t feet_run_b_bmp [0:13] = '{
        82'b0000000000000000000011111111111100000000111100000000000000000000000000000000000000,
        82'b0000000000000000000011111111111100000000111100000000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000111111111100000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000111111111100000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000000000000000000000000000000000000000000000,
        82'b0000000000000000000011111100000000000000000000000000000000000000000000000000000000,
        82'b0000000000000000000011110000000000000000000000000000000000000000000000000000000000,
        82'b0000000000000000000011110000000000000000000000000000000000000000000000000000000000,
        82'b0000000000000000000011110000000000000000000000000000000000000000000000000000000000,
        82'b0000000000000000000011110000000000000000000000000000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000000000000000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000000000000000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000000000000000000000000000000000000000000000,
        82'b0000000000000000000011111111000000000000000000000000000000000000000000000000000000
    };

endpackage

// File: design/dino_game_pkg.sv
package dino_game_pkg;

    typedef enum logic [1:0] {
        st_initial,
        st_play,
        st_bot,
        st_dead
    } game_state_e;

    typedef logic [9:0]  coord_t;       // screen x or y
    typedef logic [11:0] jump_time_t;   // frames into a jump
    typedef logic [11:0] height_t;      // pixels above ground

    localparam jump_time_t jump_frames = 12'd40;

    // sprite placement on screen
    localparam coord_t ground_y = 10'd402;  // row just below the feet
    localparam coord_t dino_x   = 10'd80;
    localparam coord_t dino_w   = 10'd82;
    localparam coord_t body_h   = 10'd74;
    localparam coord_t feet_h   = 10'd14;

endpackage
